//--- hw/rvv_pkg.sv
/*
  Vector ISA types used by the mask unit front end. Covers element widths,
  the vtype layout and the mask opcode subset seen at issue.
*/
package rvv_pkg;

  // Element width as log2 of its byte count
  typedef enum logic [1:0] {
    EW8  = 2'b00,
    EW16 = 2'b01,
    EW32 = 2'b10,
    EW64 = 2'b11
  } vew_e;

  // vtype CSR layout
  typedef struct packed {
    logic       vill;
    logic       vma;
    logic       vta;
    vew_e       vsew;
    logic [2:0] vlmul;
  } vtype_t;

  // Mask opcodes handled by the unit
  // Comparisons and carry ops are kept contiguous from VMFEQ to VMSBC
  typedef enum logic [3:0] {
    VMANDNOT,
    VMAND,
    VMOR,
    VMXOR,
    VMFEQ,
    VMSEQ,
    VMSLT,
    VMADC,
    VMSBC
  } masku_op_e;

endpackage

//--- hw/masku_pkg.sv
/*
  Mask unit parameters, lane operand bundles and the issue request.
  Also holds the byte shuffle mapping between lane order and sequential order.
*/
package masku_pkg;

  localparam int unsigned NrLanes       = 4;
  localparam int unsigned ELEN          = 64;
  localparam int unsigned ELENB         = ELEN / 8;
  localparam int unsigned DatapathWidth = NrLanes * ELEN;

  typedef logic [ELEN-1:0] elen_t;

  // Functional unit that produces the compare result
  typedef enum logic {
    MaskFuAlu = 1'b0,
    MaskFuFpu = 1'b1
  } masku_fu_e;

  // Words delivered by one lane
  typedef struct packed {
    elen_t m;
    elen_t vd;
    elen_t alu;
    elen_t fpu;
  } lane_ops_t;

  // One handshake flag per lane word
  typedef struct packed {
    logic m;
    logic vd;
    logic alu;
    logic fpu;
  } lane_vld_t;

  typedef struct packed {
    rvv_pkg::masku_op_e op;
    logic               vm;
    rvv_pkg::vtype_t    vtype;
    rvv_pkg::vew_e      eew_vs2;
    rvv_pkg::vew_e      eew_vd_op;
    rvv_pkg::vew_e      eew_vmask;
  } masku_req_t;

  // ------------------------------------------------------------------
  // Byte shuffle mapping
  // ------------------------------------------------------------------

  // Sequential byte b to its position in the lane-interleaved datapath
  function automatic int unsigned shuffle_index(int unsigned b, rvv_pkg::vew_e eew);
    int unsigned ew;
    int unsigned elem;
    ew   = 1 << int'(eew);
    elem = b / ew;
    return (elem % NrLanes) * ELENB + (elem / NrLanes) * ew + b % ew;
  endfunction

  // Inverse of shuffle_index
  function automatic int unsigned deshuffle_index(int unsigned s, rvv_pkg::vew_e eew);
    int unsigned ew;
    int unsigned lane;
    int unsigned off;
    ew   = 1 << int'(eew);
    lane = s / ELENB;
    off  = s % ELENB;
    return ((off / ew) * NrLanes + lane) * ew + off % ew;
  endfunction

endpackage

//--- hw/spill_register.sv
/*
  Two-entry valid/ready buffer for one operand word. Input ready depends
  on register state only, which breaks the combinational ready path.
*/
`timescale 1ns/1ns

module spill_register (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             valid_i,
  output logic             ready_o,
  input  masku_pkg::elen_t data_i,
  output logic             valid_o,
  input  logic             ready_i,
  output masku_pkg::elen_t data_o
);

  import masku_pkg::*;

  elen_t a_data_q;
  elen_t b_data_q;
  logic  a_full_q;
  logic  b_full_q;
  logic  a_fill;
  logic  a_drain;
  logic  b_fill;
  logic  b_drain;

  // A takes new words, moves on whenever B is empty
  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;

  // B only catches a word from A when the consumer stalls
  assign b_fill  = a_drain && !ready_i;
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_fill || (a_full_q && !a_drain);
      b_full_q <= b_fill || (b_full_q && !b_drain);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= data_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  // B always holds the older word when both are full
  assign ready_o = !a_full_q || !b_full_q;
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

//--- hw/masku_deshuffle.sv
/*
  Reorders a lane-interleaved datapath into sequential byte order.
  Purely combinational; the element width selects the mapping.
*/
`timescale 1ns/1ns

module masku_deshuffle (
  input  logic [masku_pkg::DatapathWidth-1:0] shuffled_i,
  input  rvv_pkg::vew_e                       eew_i,
  output logic [masku_pkg::DatapathWidth-1:0] seq_o
);

  import masku_pkg::*;

  // Each sequential byte pulls from its lane position
  always_comb begin
    for (int unsigned b = 0; b < NrLanes * ELENB; b++) begin
      seq_o[8*b +: 8] = shuffled_i[8*shuffle_index(b, eew_i) +: 8];
    end
  end

endmodule

//--- hw/masku_bit_enable.sv
/*
  Builds the shuffled bit enable for masked mask-unit instructions.
  The mask operand comes from the m spill registers in lane order.
*/
`timescale 1ns/1ns

module masku_bit_enable (
  input  masku_pkg::masku_req_t                 req_i,
  input  masku_pkg::elen_t [masku_pkg::NrLanes-1:0] mask_i,
  output logic [masku_pkg::DatapathWidth-1:0]   bit_enable_o
);

  import rvv_pkg::*;
  import masku_pkg::*;

  logic [DatapathWidth-1:0] mask_flat;
  vew_e                     src_eew;
  logic                     all_active;

  assign mask_flat = mask_i;

  // Compares and carries are laid out by SEW, the rest by the vd width
  assign src_eew = (req_i.op inside {[VMFEQ:VMSBC]}) ? req_i.vtype.vsew : req_i.eew_vd_op;

  // VMADC and VMSBC read v0 as carry input, not as a mask
  assign all_active = req_i.vm || (req_i.op inside {VMADC, VMSBC});

  // ------------------------------------------------------------------
  // Byte remap from mask layout to source layout
  // ------------------------------------------------------------------
  always_comb begin
    bit_enable_o = '1;
    if (!all_active) begin
      for (int unsigned b = 0; b < NrLanes * ELENB; b++) begin
        bit_enable_o[8*shuffle_index(b, src_eew) +: 8] =
          mask_flat[8*shuffle_index(b, req_i.eew_vmask) +: 8];
      end
    end
  end

endmodule

//--- hw/masku_operands.sv
/*
  Unpacks the lane operand bundles, selects the ALU or FPU result and
  buffers vd and v0 per lane in spill registers. Lane readies are routed
  back to the matching field of each bundle.
*/
`timescale 1ns/1ns

module masku_operands (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  masku_pkg::masku_fu_e                      fu_i,
  // Lane side
  input  masku_pkg::lane_ops_t [masku_pkg::NrLanes-1:0] ops_i,
  input  masku_pkg::lane_vld_t [masku_pkg::NrLanes-1:0] ops_valid_i,
  output masku_pkg::lane_vld_t [masku_pkg::NrLanes-1:0] ops_ready_o,
  // Selected functional unit result
  output masku_pkg::elen_t [masku_pkg::NrLanes-1:0] alu_o,
  output logic [masku_pkg::NrLanes-1:0]             alu_valid_o,
  input  logic [masku_pkg::NrLanes-1:0]             alu_ready_i,
  // Destination register
  output masku_pkg::elen_t [masku_pkg::NrLanes-1:0] vd_o,
  output logic [masku_pkg::NrLanes-1:0]             vd_valid_o,
  input  logic [masku_pkg::NrLanes-1:0]             vd_ready_i,
  input  logic [masku_pkg::NrLanes-1:0]             vd_seq_ready_i,
  // Mask register v0
  output masku_pkg::elen_t [masku_pkg::NrLanes-1:0] m_o,
  output logic [masku_pkg::NrLanes-1:0]             m_valid_o,
  input  logic [masku_pkg::NrLanes-1:0]             m_ready_i,
  input  logic [masku_pkg::NrLanes-1:0]             m_seq_ready_i
);

  import masku_pkg::*;

  logic [NrLanes-1:0] vd_lane_ready;
  logic [NrLanes-1:0] m_lane_ready;
  logic [NrLanes-1:0] vd_spill_ready;
  logic [NrLanes-1:0] m_spill_ready;

  // Either consumer of a word may drain the shared buffer
  assign vd_spill_ready = vd_ready_i | vd_seq_ready_i;
  assign m_spill_ready  = m_ready_i | m_seq_ready_i;

  for (genvar lane = 0; lane < NrLanes; lane++) begin : gen_lane
    // ----------------------------------------------------------------
    // ALU/FPU selection without buffering
    // ----------------------------------------------------------------
    assign alu_o[lane] = (fu_i == MaskFuFpu) ? ops_i[lane].fpu : ops_i[lane].alu;
    assign alu_valid_o[lane] = (fu_i == MaskFuFpu) ? ops_valid_i[lane].fpu
                                                   : ops_valid_i[lane].alu;

    // ----------------------------------------------------------------
    // vd and v0 buffering
    // ----------------------------------------------------------------
    spill_register i_spill_vd (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .valid_i (ops_valid_i[lane].vd),
      .ready_o (vd_lane_ready[lane]),
      .data_i  (ops_i[lane].vd),
      .valid_o (vd_valid_o[lane]),
      .ready_i (vd_spill_ready[lane]),
      .data_o  (vd_o[lane])
    );

    spill_register i_spill_m (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .valid_i (ops_valid_i[lane].m),
      .ready_o (m_lane_ready[lane]),
      .data_i  (ops_i[lane].m),
      .valid_o (m_valid_o[lane]),
      .ready_i (m_spill_ready[lane]),
      .data_o  (m_o[lane])
    );
  end

  // Only the selected unit sees the consumer ready
  always_comb begin
    for (int lane = 0; lane < NrLanes; lane++) begin
      ops_ready_o[lane].m   = m_lane_ready[lane];
      ops_ready_o[lane].vd  = vd_lane_ready[lane];
      ops_ready_o[lane].alu = (fu_i == MaskFuAlu) && alu_ready_i[lane];
      ops_ready_o[lane].fpu = (fu_i == MaskFuFpu) && alu_ready_i[lane];
    end
  end

endmodule

//--- hw/masku_operand_stage.sv
/*
  Operand front end of the mask unit. Joins the operand block with the
  three deshufflers and the bit enable generator.
*/
`timescale 1ns/1ns

module masku_operand_stage (
  input  logic                                      clk_i,
  input  logic                                      reset_i,
  input  masku_pkg::masku_req_t                     req_i,
  input  masku_pkg::masku_fu_e                      fu_i,
  // Lane side
  input  masku_pkg::lane_ops_t [masku_pkg::NrLanes-1:0] ops_i,
  input  masku_pkg::lane_vld_t [masku_pkg::NrLanes-1:0] ops_valid_i,
  output masku_pkg::lane_vld_t [masku_pkg::NrLanes-1:0] ops_ready_o,
  // ALU/FPU result
  output masku_pkg::elen_t [masku_pkg::NrLanes-1:0] alu_o,
  output logic [masku_pkg::DatapathWidth-1:0]       alu_seq_o,
  output logic [masku_pkg::NrLanes-1:0]             alu_valid_o,
  input  logic [masku_pkg::NrLanes-1:0]             alu_ready_i,
  // vd
  output masku_pkg::elen_t [masku_pkg::NrLanes-1:0] vd_o,
  output logic [masku_pkg::DatapathWidth-1:0]       vd_seq_o,
  output logic [masku_pkg::NrLanes-1:0]             vd_valid_o,
  input  logic [masku_pkg::NrLanes-1:0]             vd_ready_i,
  input  logic [masku_pkg::NrLanes-1:0]             vd_seq_ready_i,
  // v0
  output masku_pkg::elen_t [masku_pkg::NrLanes-1:0] m_o,
  output logic [masku_pkg::DatapathWidth-1:0]       m_seq_o,
  output logic [masku_pkg::NrLanes-1:0]             m_valid_o,
  input  logic [masku_pkg::NrLanes-1:0]             m_ready_i,
  input  logic [masku_pkg::NrLanes-1:0]             m_seq_ready_i,
  // Bit enable, shuffled like the source operand
  output logic [masku_pkg::DatapathWidth-1:0]       bit_enable_o
);

  masku_operands i_operands (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .fu_i           (fu_i),
    .ops_i          (ops_i),
    .ops_valid_i    (ops_valid_i),
    .ops_ready_o    (ops_ready_o),
    .alu_o          (alu_o),
    .alu_valid_o    (alu_valid_o),
    .alu_ready_i    (alu_ready_i),
    .vd_o           (vd_o),
    .vd_valid_o     (vd_valid_o),
    .vd_ready_i     (vd_ready_i),
    .vd_seq_ready_i (vd_seq_ready_i),
    .m_o            (m_o),
    .m_valid_o      (m_valid_o),
    .m_ready_i      (m_ready_i),
    .m_seq_ready_i  (m_seq_ready_i)
  );

  // Sequential copies, each by its own element width
  masku_deshuffle i_deshuffle_alu (
    .shuffled_i (alu_o),
    .eew_i      (req_i.eew_vs2),
    .seq_o      (alu_seq_o)
  );

  masku_deshuffle i_deshuffle_vd (
    .shuffled_i (vd_o),
    .eew_i      (req_i.eew_vd_op),
    .seq_o      (vd_seq_o)
  );

  masku_deshuffle i_deshuffle_m (
    .shuffled_i (m_o),
    .eew_i      (req_i.eew_vmask),
    .seq_o      (m_seq_o)
  );

  masku_bit_enable i_bit_enable (
    .req_i        (req_i),
    .mask_i       (m_o),
    .bit_enable_o (bit_enable_o)
  );

endmodule

//--- tests/masku_assert.sv
/*
  Concurrent checks on the operand block, attached by bind from the
  testbench. Covers valid hold on the buffered outputs, unit selection and reset.
*/
`timescale 1ns/1ns

module masku_assert (
  input logic                                          clk_i,
  input logic                                          reset_i,
  input masku_pkg::masku_fu_e                          fu_i,
  input masku_pkg::lane_vld_t [masku_pkg::NrLanes-1:0] ops_ready_i,
  input logic [masku_pkg::NrLanes-1:0]                 alu_valid_i,
  input logic [masku_pkg::NrLanes-1:0]                 alu_ready_i,
  input logic [masku_pkg::NrLanes-1:0]                 vd_valid_i,
  input logic [masku_pkg::NrLanes-1:0]                 vd_drain_i,
  input masku_pkg::elen_t [masku_pkg::NrLanes-1:0]     vd_i,
  input logic [masku_pkg::NrLanes-1:0]                 m_valid_i,
  input logic [masku_pkg::NrLanes-1:0]                 m_drain_i,
  input masku_pkg::elen_t [masku_pkg::NrLanes-1:0]     m_i
);

  import masku_pkg::*;

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lane
    // A stalled word keeps its valid and its value
    vd_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      vd_valid_i[l] && !vd_drain_i[l] |=> vd_valid_i[l] && $stable(vd_i[l]))
      else $error("vd word in lane %0d changed before it was taken", l);

    m_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      m_valid_i[l] && !m_drain_i[l] |=> m_valid_i[l] && $stable(m_i[l]))
      else $error("mask word in lane %0d changed before it was taken", l);

    alu_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      alu_valid_i[l] && !alu_ready_i[l] |=> alu_valid_i[l])
      else $error("selected unit valid in lane %0d dropped while stalled", l);

    // The idle unit never sees a ready
    unsel_ready: assert property (@(posedge clk_i)
      (fu_i == MaskFuAlu) ? !ops_ready_i[l].fpu : !ops_ready_i[l].alu)
      else $error("unselected unit got a ready in lane %0d", l);
  end

  reset_empty: assert property (@(posedge clk_i)
    reset_i |=> (vd_valid_i == '0) && (m_valid_i == '0))
    else $error("buffered valids not cleared by reset");

endmodule

//--- tests/tb_masku.sv
/*
  Testbench for the mask unit operand front end. Random lane traffic and
  readies come from an LFSR, and every output is checked against a model.
*/
`timescale 1ns/1ns

module tb_masku;

  import rvv_pkg::*;
  import masku_pkg::*;

  typedef logic [DatapathWidth-1:0] word_t;

  localparam int NrBytes     = NrLanes * ELENB;
  localparam int ResetCycles = 16;
  localparam int Segments    = 8;
  localparam int SegCycles   = 200;
  // Reset plus each segment with room for its drain plus a few final cycles
  localparam int MaxCycles   = ResetCycles + Segments * (SegCycles + 20) + 24;

  logic                    clk_i;
  logic                    reset_i;
  masku_req_t              req_i;
  masku_fu_e               fu_i;
  lane_ops_t [NrLanes-1:0] ops_i;
  lane_vld_t [NrLanes-1:0] ops_valid_i;
  lane_vld_t [NrLanes-1:0] ops_ready_o;
  elen_t [NrLanes-1:0]     alu_o;
  elen_t [NrLanes-1:0]     vd_o;
  elen_t [NrLanes-1:0]     m_o;
  word_t                   alu_seq_o;
  word_t                   vd_seq_o;
  word_t                   m_seq_o;
  word_t                   bit_enable_o;
  logic [NrLanes-1:0]      alu_valid_o;
  logic [NrLanes-1:0]      alu_ready_i;
  logic [NrLanes-1:0]      vd_valid_o;
  logic [NrLanes-1:0]      vd_ready_i;
  logic [NrLanes-1:0]      vd_seq_ready_i;
  logic [NrLanes-1:0]      m_valid_o;
  logic [NrLanes-1:0]      m_ready_i;
  logic [NrLanes-1:0]      m_seq_ready_i;

  logic [31:0]             lfsr_q;
  logic                    stim_on;
  lane_vld_t [NrLanes-1:0] taken_q;
  int unsigned             cycle_cnt = 0;
  // Words held by each spill register with the oldest in front
  elen_t                   vd_q[NrLanes][$];
  elen_t                   m_q[NrLanes][$];

  masku_operand_stage DUT (.*);

  bind masku_operands masku_assert i_masku_assert (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .fu_i        (fu_i),
    .ops_ready_i (ops_ready_o),
    .alu_valid_i (alu_valid_o),
    .alu_ready_i (alu_ready_i),
    .vd_valid_i  (vd_valid_o),
    .vd_drain_i  (vd_spill_ready),
    .vd_i        (vd_o),
    .m_valid_i   (m_valid_o),
    .m_drain_i   (m_spill_ready),
    .m_i         (m_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MaxCycles) begin
      $display("Timeout after %0d cycles, the buffers never drained", cycle_cnt);
      $display(">>> FAIL");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------

  // Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic rand_bit();
    logic lsb;
    lsb    = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (lsb) lfsr_q = lfsr_q ^ 32'h8020_0003;
    return lsb;
  endfunction

  function automatic elen_t rand_word();
    elen_t w;
    for (int i = 0; i < ELEN; i++) w[i] = rand_bit();
    return w;
  endfunction

  // A pending word stays until taken and only then may a fresh one be offered
  function automatic logic [ELEN:0] next_offer(logic valid, logic taken, elen_t data);
    if (valid && !taken) return {valid, data};
    return {stim_on && rand_bit(), rand_word()};
  endfunction

  task automatic new_request();
    masku_req_t r;
    for (int i = 0; i < $bits(r); i++) r[i] = rand_bit();
    // Fold the unused opcode codes back into the valid range
    if (r.op > VMSBC) r.op = masku_op_e'(r.op - 4'd8);
    req_i = r;
    fu_i  = masku_fu_e'(rand_bit());
  endtask

  task automatic drive_inputs();
    for (int l = 0; l < NrLanes; l++) begin
      {ops_valid_i[l].vd, ops_i[l].vd} =
        next_offer(ops_valid_i[l].vd, taken_q[l].vd, ops_i[l].vd);
      {ops_valid_i[l].m, ops_i[l].m} =
        next_offer(ops_valid_i[l].m, taken_q[l].m, ops_i[l].m);
      if (fu_i == MaskFuAlu) begin
        {ops_valid_i[l].alu, ops_i[l].alu} =
          next_offer(ops_valid_i[l].alu, taken_q[l].alu, ops_i[l].alu);
        ops_valid_i[l].fpu = 1'b0;
        ops_i[l].fpu       = rand_word();
      end else begin
        {ops_valid_i[l].fpu, ops_i[l].fpu} =
          next_offer(ops_valid_i[l].fpu, taken_q[l].fpu, ops_i[l].fpu);
        ops_valid_i[l].alu = 1'b0;
        ops_i[l].alu       = rand_word();
      end
      alu_ready_i[l]    = !stim_on || rand_bit();
      vd_ready_i[l]     = !stim_on || rand_bit();
      vd_seq_ready_i[l] = !stim_on || rand_bit();
      m_ready_i[l]      = !stim_on || rand_bit();
      m_seq_ready_i[l]  = !stim_on || rand_bit();
    end
  endtask

  // ------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------

  // Element e goes to lane e mod NrLanes, row e div NrLanes of that lane
  function automatic int lane_byte_pos(int b, vew_e eew);
    int ew;
    int elem;
    case (eew)
      EW8:     ew = 1;
      EW16:    ew = 2;
      EW32:    ew = 4;
      default: ew = 8;
    endcase
    elem = b / ew;
    return (elem % NrLanes) * ELENB + (elem / NrLanes) * ew + b % ew;
  endfunction

  function automatic word_t model_deshuffle(word_t shuffled, vew_e eew);
    word_t seq;
    for (int b = 0; b < NrBytes; b++) begin
      seq[8*b +: 8] = shuffled[8*lane_byte_pos(b, eew) +: 8];
    end
    return seq;
  endfunction

  function automatic word_t model_bit_enable(masku_req_t req, word_t mask);
    word_t be;
    vew_e  src;
    be = '1;
    if (req.vm || req.op == VMADC || req.op == VMSBC) return be;
    src = (req.op >= VMFEQ && req.op <= VMSBC) ? req.vtype.vsew : req.eew_vd_op;
    for (int b = 0; b < NrBytes; b++) begin
      be[8*lane_byte_pos(b, src) +: 8] = mask[8*lane_byte_pos(b, req.eew_vmask) +: 8];
    end
    return be;
  endfunction

  // ------------------------------------------------------------------
  // Checks
  // ------------------------------------------------------------------

  task automatic check_equal(string name, word_t expected, word_t actual);
    if (expected !== actual) begin
      $display("ERR %s expected %0h actual %0h", name, expected, actual);
      $display(">>> FAIL");
      $fatal(1, "Value mismatch in %s", name);
    end
  endtask

  task automatic check_outputs();
    elen_t [NrLanes-1:0] sel_word;
    elen_t [NrLanes-1:0] vd_head;
    elen_t [NrLanes-1:0] m_head;
    logic                sel_valid;
    logic                sel_ready;
    logic                other_ready;
    string               tag;
    vd_head = '0;
    m_head  = '0;
    for (int l = 0; l < NrLanes; l++) begin
      tag         = $sformatf("lane %0d", l);
      sel_word[l] = (fu_i == MaskFuFpu) ? ops_i[l].fpu : ops_i[l].alu;
      sel_valid   = (fu_i == MaskFuFpu) ? ops_valid_i[l].fpu : ops_valid_i[l].alu;
      sel_ready   = (fu_i == MaskFuFpu) ? ops_ready_o[l].fpu : ops_ready_o[l].alu;
      other_ready = (fu_i == MaskFuFpu) ? ops_ready_o[l].alu : ops_ready_o[l].fpu;
      check_equal({"alu_valid ", tag}, word_t'(sel_valid), word_t'(alu_valid_o[l]));
      if (sel_valid) check_equal({"alu ", tag}, word_t'(sel_word[l]), word_t'(alu_o[l]));
      check_equal({"fu ready ", tag}, word_t'(alu_ready_i[l]), word_t'(sel_ready));
      check_equal({"unselected ready ", tag}, '0, word_t'(other_ready));
      // Spill register holds what the queue holds and never more than two words
      check_equal({"vd_valid ", tag}, word_t'(vd_q[l].size() != 0), word_t'(vd_valid_o[l]));
      check_equal({"vd lane ready ", tag}, word_t'(vd_q[l].size() < 2),
                  word_t'(ops_ready_o[l].vd));
      if (vd_valid_o[l]) begin
        vd_head[l] = vd_q[l][0];
        check_equal({"vd ", tag}, word_t'(vd_head[l]), word_t'(vd_o[l]));
      end
      check_equal({"m_valid ", tag}, word_t'(m_q[l].size() != 0), word_t'(m_valid_o[l]));
      check_equal({"m lane ready ", tag}, word_t'(m_q[l].size() < 2),
                  word_t'(ops_ready_o[l].m));
      if (m_valid_o[l]) begin
        m_head[l] = m_q[l][0];
        check_equal({"m ", tag}, word_t'(m_head[l]), word_t'(m_o[l]));
      end
    end
    check_equal("alu_seq", model_deshuffle(sel_word, req_i.eew_vs2), alu_seq_o);
    if (&vd_valid_o) check_equal("vd_seq", model_deshuffle(vd_head, req_i.eew_vd_op), vd_seq_o);
    if (&m_valid_o) begin
      check_equal("m_seq", model_deshuffle(m_head, req_i.eew_vmask), m_seq_o);
      check_equal("bit_enable", model_bit_enable(req_i, m_head), bit_enable_o);
    end
    // Handshakes that complete at the coming rising edge
    for (int l = 0; l < NrLanes; l++) begin
      taken_q[l] = ops_valid_i[l] & ops_ready_o[l];
      if (vd_valid_o[l] && (vd_ready_i[l] || vd_seq_ready_i[l])) void'(vd_q[l].pop_front());
      if (m_valid_o[l] && (m_ready_i[l] || m_seq_ready_i[l])) void'(m_q[l].pop_front());
      if (taken_q[l].vd) vd_q[l].push_back(ops_i[l].vd);
      if (taken_q[l].m) m_q[l].push_back(ops_i[l].m);
    end
  endtask

  // Nothing offered by the lanes and nothing buffered
  function automatic logic idle();
    logic busy;
    busy = |ops_valid_i;
    for (int l = 0; l < NrLanes; l++) begin
      busy |= (vd_q[l].size() != 0) || (m_q[l].size() != 0);
    end
    return !busy;
  endfunction

  task automatic run_cycle();
    @(negedge clk_i);
    drive_inputs();
    #10;
    check_outputs();
  endtask

  // ------------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------------
  initial begin
    lfsr_q         = 32'hcba4;
    reset_i        = 1'b1;
    stim_on        = 1'b0;
    req_i          = '0;
    fu_i           = MaskFuAlu;
    ops_i          = '0;
    ops_valid_i    = '0;
    taken_q        = '0;
    alu_ready_i    = '0;
    vd_ready_i     = '0;
    vd_seq_ready_i = '0;
    m_ready_i      = '0;
    m_seq_ready_i  = '0;
    repeat (ResetCycles) @(negedge clk_i);
    reset_i = 1'b0;
    #10;
    check_equal("valids after reset", '0, word_t'({alu_valid_o, vd_valid_o, m_valid_o}));
    for (int s = 0; s < Segments; s++) begin
      new_request();
      stim_on = 1'b1;
      repeat (SegCycles) run_cycle();
      // No new offers and all readies high until every buffer is empty
      stim_on = 1'b0;
      while (!idle()) run_cycle();
    end
    run_cycle();
    check_equal("valids after drain", '0, word_t'({vd_valid_o, m_valid_o}));
    $display(">>> PASS");
    $finish;
  end

endmodule

//--- masku.f
hw/rvv_pkg.sv
hw/masku_pkg.sv
hw/spill_register.sv
hw/masku_deshuffle.sv
hw/masku_bit_enable.sv
hw/masku_operands.sv
hw/masku_operand_stage.sv
tests/masku_assert.sv
tests/tb_masku.sv

//--- Makefile
TOP := tb_masku

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f masku.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f masku.f --top-module $(TOP) -o V$(TOP)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir
